// ==== design/zhxpu_params.svh ====
`ifndef ZHXPU_PARAMS_SVH
`define ZHXPU_PARAMS_SVH

// Datapath width and register count
`define ZX_WORD 16
`define ZX_REGS 8

// Memory sizes in words
`define ZX_IMEM_DEPTH 64
`define ZX_DMEM_DEPTH 64

// Cycles per data access
`define ZX_MEM_LATENCY 3

`endif

// ==== design/zhxpu_pkg.sv ====
`default_nettype none

package zhxpu_pkg;

	typedef enum logic [4:0] {
		OP_NOP   = 5'd0,
		OP_ALU   = 5'd1,
		OP_ADDIU = 5'd2,
		OP_LI    = 5'd3,
		OP_LW    = 5'd4,
		OP_SW    = 5'd5,
		OP_BEQZ  = 5'd6,
		OP_B     = 5'd7,
		OP_HALT  = 5'd8
	} opcode_e;

	typedef enum logic [1:0] {
		FN_ADD = 2'd0,
		FN_SUB = 2'd1,
		FN_AND = 2'd2,
		FN_OR  = 2'd3
	} alu_fn_e;

	// Register form and immediate form of one word
	typedef union packed {
		struct packed {
			opcode_e    op;
			logic [2:0] rx;
			logic [2:0] ry;
			logic [2:0] rz;
			alu_fn_e    funct;
		} r_fmt;
		struct packed {
			opcode_e    op;
			logic [2:0] rx;
			logic [7:0] imm8;
		} i_fmt;
	} instr_t;

endpackage

`default_nettype wire

// ==== design/stall_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "zhxpu_params.svh"

module stall_ctrl (
	input  logic                        clk,
	input  logic                        rst,
	input  zhxpu_pkg::instr_t           id_instr,
	input  logic [$clog2(`ZX_REGS)-1:0] exe_dest,
	input  logic                        exe_wr,
	input  logic                        mem_busy,
	input  logic                        branch_taken,
	output logic                        hold,
	output logic                        bubble,
	output logic                        flush
);
	import zhxpu_pkg::*;

	logic use_rx;
	logic use_ry;
	logic hazard;

	// Register fields read by the instruction in decode
	always_comb begin
		use_rx = 1'b0;
		use_ry = 1'b0;
		case (id_instr.r_fmt.op)
			OP_ALU, OP_SW: begin
				use_rx = 1'b1;
				use_ry = 1'b1;
			end
			OP_ADDIU, OP_BEQZ: use_rx = 1'b1;
			OP_LW: use_ry = 1'b1;
			default: ;
		endcase
	end

	assign hazard = exe_wr && ((use_rx && id_instr.r_fmt.rx == exe_dest) ||
		(use_ry && id_instr.r_fmt.ry == exe_dest));

	assign hold = mem_busy;
	assign bubble = hazard && !hold;
	assign flush = branch_taken && !hold && !bubble;

	// Flushed slot reaches decode as a NOP, so no second flush follows
	a_flush_once: assert property (@(posedge clk) disable iff (rst)
		flush |=> !flush);

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "zhxpu_params.svh"

module fetch_unit (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              start,
	input  logic                              prog_we,
	input  logic [$clog2(`ZX_IMEM_DEPTH)-1:0] prog_addr,
	input  logic [`ZX_WORD-1:0]               prog_data,
	input  logic                              hold,
	input  logic                              bubble,
	input  logic                              flush,
	input  logic                              branch_taken,
	input  logic [`ZX_WORD-1:0]               branch_target,
	input  logic                              halt_seen,
	output zhxpu_pkg::instr_t                 id_instr,
	output logic [`ZX_WORD-1:0]               id_pc
);
	import zhxpu_pkg::*;

	localparam int W = `ZX_WORD;
	localparam int IAW = $clog2(`ZX_IMEM_DEPTH);

	logic [W-1:0] imem [`ZX_IMEM_DEPTH];
	logic [W-1:0] pc;
	logic         running;
	logic         advance;
	logic         stage_en;
	instr_t       if_word;

	always_ff @(posedge clk) begin
		if (prog_we) begin
			imem[prog_addr] <= prog_data;
		end
	end

	assign if_word = imem[pc[IAW-1:0]];
	assign stage_en = !hold && !bubble;
	assign advance = running && stage_en;

	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
		end else if (start) begin
			running <= 1'b1;
		end else if (halt_seen) begin
			running <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || start) begin
			pc <= '0;
		end else if (advance) begin
			pc <= branch_taken ? branch_target : pc + W'(1);
		end
	end

	// IF/ID, NOP while idle or behind a taken branch or HALT
	always_ff @(posedge clk) begin
		if (rst) begin
			id_instr <= '0;
		end else if (stage_en) begin
			if (flush || halt_seen || !running) begin
				id_instr <= '0;
			end else begin
				id_instr <= if_word;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (stage_en) begin
			id_pc <= pc;
		end
	end

	a_load_idle: assert property (@(posedge clk) disable iff (rst)
		running |-> !prog_we);

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "zhxpu_params.svh"

module reg_file (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [$clog2(`ZX_REGS)-1:0] raddr1,
	input  logic [$clog2(`ZX_REGS)-1:0] raddr2,
	input  logic                        wr_en,
	input  logic [$clog2(`ZX_REGS)-1:0] wr_addr,
	input  logic [`ZX_WORD-1:0]         wr_value,
	output logic [`ZX_WORD-1:0]         rdata1,
	output logic [`ZX_WORD-1:0]         rdata2
);
	logic [`ZX_WORD-1:0] regs [`ZX_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `ZX_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_value;
		end
	end

	// Write-through so decode sees the result in write-back
	assign rdata1 = (wr_en && wr_addr == raddr1) ? wr_value : regs[raddr1];
	assign rdata2 = (wr_en && wr_addr == raddr2) ? wr_value : regs[raddr2];

endmodule

`default_nettype wire

// ==== design/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "zhxpu_params.svh"

module decoder (
	input  logic                        clk,
	input  logic                        rst,
	input  zhxpu_pkg::instr_t           id_instr,
	input  logic [`ZX_WORD-1:0]         id_pc,
	input  logic [`ZX_WORD-1:0]         rdata1,
	input  logic [`ZX_WORD-1:0]         rdata2,
	input  logic                        hold,
	input  logic                        bubble,
	output logic [$clog2(`ZX_REGS)-1:0] raddr1,
	output logic [$clog2(`ZX_REGS)-1:0] raddr2,
	output zhxpu_pkg::opcode_e          exe_op,
	output zhxpu_pkg::alu_fn_e          exe_fn,
	output logic [`ZX_WORD-1:0]         exe_a,
	output logic [`ZX_WORD-1:0]         exe_b,
	output logic [$clog2(`ZX_REGS)-1:0] exe_dest,
	output logic                        exe_wr,
	output logic                        mem_rd,
	output logic                        mem_wr,
	output logic                        branch_taken,
	output logic [`ZX_WORD-1:0]         branch_target,
	output logic                        halt_seen
);
	import zhxpu_pkg::*;

	localparam int W = `ZX_WORD;

	opcode_e                     op;
	alu_fn_e                     d_fn;
	logic [W-1:0]                d_a;
	logic [W-1:0]                d_b;
	logic [W-1:0]                simm;
	logic [W-1:0]                zimm;
	logic [$clog2(`ZX_REGS)-1:0] d_dest;
	logic                        d_wr;
	logic                        d_rd;
	logic                        d_wrm;

	assign op = id_instr.r_fmt.op;
	assign raddr1 = id_instr.r_fmt.rx;
	assign raddr2 = id_instr.r_fmt.ry;
	assign simm = {{(W-8){id_instr.i_fmt.imm8[7]}}, id_instr.i_fmt.imm8};
	assign zimm = {{(W-8){1'b0}}, id_instr.i_fmt.imm8};

	// Immediate forms go to the adder as operand b
	always_comb begin
		d_fn = FN_ADD;
		d_a = rdata1;
		d_b = rdata2;
		d_dest = id_instr.r_fmt.rz;
		d_wr = 1'b0;
		d_rd = 1'b0;
		d_wrm = 1'b0;
		case (op)
			OP_ALU: begin
				d_fn = id_instr.r_fmt.funct;
				d_wr = 1'b1;
			end
			OP_ADDIU: begin
				d_b = simm;
				d_dest = id_instr.i_fmt.rx;
				d_wr = 1'b1;
			end
			OP_LI: begin
				d_a = '0;
				d_b = zimm;
				d_dest = id_instr.i_fmt.rx;
				d_wr = 1'b1;
			end
			OP_LW: begin
				d_rd = 1'b1;
				d_wr = 1'b1;
			end
			OP_SW: d_wrm = 1'b1;
			default: ;
		endcase
	end

	// Branches resolve here, BEQZ tests rx
	assign branch_target = id_pc + W'(1) + simm;
	assign branch_taken = (op == OP_B) || (op == OP_BEQZ && rdata1 == '0);
	assign halt_seen = (op == OP_HALT);

	always_ff @(posedge clk) begin
		if (rst) begin
			exe_op <= OP_NOP;
			exe_wr <= 1'b0;
			mem_rd <= 1'b0;
			mem_wr <= 1'b0;
		end else if (!hold) begin
			exe_op <= bubble ? OP_NOP : op;
			exe_wr <= d_wr && !bubble;
			mem_rd <= d_rd && !bubble;
			mem_wr <= d_wrm && !bubble;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			exe_fn <= d_fn;
			exe_a <= d_a;
			exe_b <= d_b;
			exe_dest <= d_dest;
		end
	end

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "zhxpu_params.svh"

module alu (
	input  logic                        clk,
	input  logic                        rst,
	input  zhxpu_pkg::opcode_e          exe_op,
	input  zhxpu_pkg::alu_fn_e          exe_fn,
	input  logic [`ZX_WORD-1:0]         exe_a,
	input  logic [`ZX_WORD-1:0]         exe_b,
	input  logic [$clog2(`ZX_REGS)-1:0] exe_dest,
	input  logic                        exe_wr,
	input  logic [`ZX_WORD-1:0]         rdata,
	input  logic                        mem_busy,
	output logic                        wb_valid,
	output logic [$clog2(`ZX_REGS)-1:0] wb_addr,
	output logic [`ZX_WORD-1:0]         wb_value,
	output logic                        halted
);
	import zhxpu_pkg::*;

	logic [`ZX_WORD-1:0] result;

	always_comb begin
		result = exe_a + exe_b;
		case (exe_fn)
			FN_SUB: result = exe_a - exe_b;
			FN_AND: result = exe_a & exe_b;
			FN_OR:  result = exe_a | exe_b;
			default: ;
		endcase
	end

	// EXE/WB waits out the memory access
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
			halted <= 1'b0;
		end else begin
			wb_valid <= exe_wr && !mem_busy;
			if (exe_op == OP_HALT) begin
				halted <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_busy) begin
			wb_addr <= exe_dest;
			wb_value <= (exe_op == OP_LW) ? rdata : result;
		end
	end

endmodule

`default_nettype wire

// ==== design/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "zhxpu_params.svh"

module data_mem (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              mem_rd,
	input  logic                              mem_wr,
	input  logic [$clog2(`ZX_DMEM_DEPTH)-1:0] addr,
	input  logic [`ZX_WORD-1:0]               wdata,
	output logic [`ZX_WORD-1:0]               rdata,
	output logic                              mem_busy
);
	localparam int LAT = `ZX_MEM_LATENCY;
	localparam int CW = $clog2(LAT);

	logic [`ZX_WORD-1:0] mem [`ZX_DMEM_DEPTH];
	logic [CW-1:0]       cnt;
	logic                access;
	logic                last;

	assign access = mem_rd || mem_wr;
	assign last = (cnt == CW'(LAT - 1));
	assign mem_busy = access && !last;

	// Cycles spent on the current access
	always_ff @(posedge clk) begin
		if (rst || !access || last) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + CW'(1);
		end
	end

	// Read data settles for the final cycle, store lands at its end
	always_ff @(posedge clk) begin
		if (mem_wr && last) begin
			mem[addr] <= wdata;
		end
		if (mem_rd && cnt == CW'(LAT - 2)) begin
			rdata <= mem[addr];
		end
	end

	a_one_access: assert property (@(posedge clk) disable iff (rst)
		!(mem_rd && mem_wr));

endmodule

`default_nettype wire

// ==== design/zhxpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "zhxpu_params.svh"

module zhxpu_core (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              start,
	input  logic                              prog_we,
	input  logic [$clog2(`ZX_IMEM_DEPTH)-1:0] prog_addr,
	input  logic [`ZX_WORD-1:0]               prog_data,
	output logic                              halted,
	output logic                              wb_valid,
	output logic [$clog2(`ZX_REGS)-1:0]       wb_addr,
	output logic [`ZX_WORD-1:0]               wb_value
);
	import zhxpu_pkg::*;

	localparam int W = `ZX_WORD;
	localparam int AW = $clog2(`ZX_REGS);

	// Stall control
	logic hold;
	logic bubble;
	logic flush;

	// IF/ID
	instr_t       id_instr;
	logic [W-1:0] id_pc;

	// Decode and register read
	logic [AW-1:0] raddr1;
	logic [AW-1:0] raddr2;
	logic [W-1:0]  rdata1;
	logic [W-1:0]  rdata2;
	logic          branch_taken;
	logic [W-1:0]  branch_target;
	logic          halt_seen;

	// ID/EXE
	opcode_e       exe_op;
	alu_fn_e       exe_fn;
	logic [W-1:0]  exe_a;
	logic [W-1:0]  exe_b;
	logic [AW-1:0] exe_dest;
	logic          exe_wr;
	logic          mem_rd;
	logic          mem_wr;

	// Data memory
	logic [W-1:0] rdata;
	logic         mem_busy;

	stall_ctrl __stall_ctrl (
		.clk(clk),
		.rst(rst),
		.id_instr(id_instr),
		.exe_dest(exe_dest),
		.exe_wr(exe_wr),
		.mem_busy(mem_busy),
		.branch_taken(branch_taken),
		.hold(hold),
		.bubble(bubble),
		.flush(flush)
	);

	fetch_unit __fetch_unit (
		.clk(clk),
		.rst(rst),
		.start(start),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.hold(hold),
		.bubble(bubble),
		.flush(flush),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.halt_seen(halt_seen),
		.id_instr(id_instr),
		.id_pc(id_pc)
	);

	reg_file __reg_file (
		.clk(clk),
		.rst(rst),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.wr_en(wb_valid),
		.wr_addr(wb_addr),
		.wr_value(wb_value),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	decoder __decoder (
		.clk(clk),
		.rst(rst),
		.id_instr(id_instr),
		.id_pc(id_pc),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.hold(hold),
		.bubble(bubble),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.exe_op(exe_op),
		.exe_fn(exe_fn),
		.exe_a(exe_a),
		.exe_b(exe_b),
		.exe_dest(exe_dest),
		.exe_wr(exe_wr),
		.mem_rd(mem_rd),
		.mem_wr(mem_wr),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.halt_seen(halt_seen)
	);

	alu __alu (
		.clk(clk),
		.rst(rst),
		.exe_op(exe_op),
		.exe_fn(exe_fn),
		.exe_a(exe_a),
		.exe_b(exe_b),
		.exe_dest(exe_dest),
		.exe_wr(exe_wr),
		.rdata(rdata),
		.mem_busy(mem_busy),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.wb_value(wb_value),
		.halted(halted)
	);

	// Address from ry, store data from rx
	data_mem __data_mem (
		.clk(clk),
		.rst(rst),
		.mem_rd(mem_rd),
		.mem_wr(mem_wr),
		.addr(exe_b[$clog2(`ZX_DMEM_DEPTH)-1:0]),
		.wdata(exe_a),
		.rdata(rdata),
		.mem_busy(mem_busy)
	);

endmodule

`default_nettype wire

// ==== verif/zhxpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "zhxpu_params.svh"

module zhxpu_tb;

	localparam int W = `ZX_WORD;
	localparam int IAW = $clog2(`ZX_IMEM_DEPTH);
	localparam int RAW = $clog2(`ZX_REGS);
	localparam int CASE_CYCLES = 200;

	logic           clk;
	logic           rst;
	logic           start;
	logic           prog_we;
	logic [IAW-1:0] prog_addr;
	logic [W-1:0]   prog_data;
	logic           halted;
	logic           wb_valid;
	logic [RAW-1:0] wb_addr;
	logic [W-1:0]   wb_value;

	// Case file contents, each case ends at the stored index
	logic [15:0] p_addr_q[$];
	logic [15:0] p_word_q[$];
	logic [15:0] w_reg_q[$];
	logic [15:0] w_val_q[$];
	int          p_end_q[$];
	int          w_end_q[$];

	int exp_idx;
	int n_value;
	int n_missing;
	int n_extra;
	int n_other;
	int n_beats;
	int cycles;
	int limit;

	zhxpu_core UUT (
		.clk(clk),
		.rst(rst),
		.start(start),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.halted(halted),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.wb_value(wb_value)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic finish_run(input bit timed_out);
		int total;
		total = n_value + n_missing + n_extra + n_other;
		$display("Errors: %0d (value %0d, missing %0d, extra %0d, other %0d), beats checked %0d",
			total, n_value, n_missing, n_extra, n_other, n_beats);
		if (!timed_out && total == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	endtask

	task automatic read_cases();
		int         fd;
		int         code;
		int         ch;
		logic [7:0] kind;
		logic [15:0] a;
		logic [15:0] v;
		bit         done;
		fd = $fopen("verif/zhxpu_cases.txt", "r");
		if (fd == 0) begin
			$display("Cannot open verif/zhxpu_cases.txt");
			n_other++;
			return;
		end
		done = 1'b0;
		while (!done) begin
			code = $fscanf(fd, " %c", kind);
			if (code != 1) begin
				done = 1'b1;
			end else if (kind == "#") begin
				ch = $fgetc(fd);
				while (ch != 10 && ch != -1) begin
					ch = $fgetc(fd);
				end
			end else if (kind == "P" || kind == "W") begin
				code = $fscanf(fd, "%h %h", a, v);
				if (code != 2) begin
					$display("Malformed %c line in the case file", kind);
					n_other++;
					done = 1'b1;
				end else if (kind == "P") begin
					p_addr_q.push_back(a);
					p_word_q.push_back(v);
				end else begin
					w_reg_q.push_back(a);
					w_val_q.push_back(v);
				end
			end else if (kind == "E") begin
				p_end_q.push_back(p_addr_q.size());
				w_end_q.push_back(w_reg_q.size());
			end else begin
				$display("Unknown line type %c in the case file", kind);
				n_other++;
				done = 1'b1;
			end
		end
		$fclose(fd);
	endtask

	task automatic check_idle();
		if (wb_valid !== 1'b0) begin
			$display("Fail: wb_valid expected %h got %h while idle", 1'b0, wb_valid);
			n_value++;
		end
		if (halted !== 1'b0) begin
			$display("Fail: halted expected %h got %h while idle", 1'b0, halted);
			n_value++;
		end
	endtask

	task automatic reset_dut();
		@(negedge clk);
		rst = 1'b1;
		repeat (16) @(negedge clk);
		check_idle();
		rst = 1'b0;
	endtask

	task automatic load_program(input int c);
		int          first;
		logic [15:0] a;
		first = (c == 0) ? 0 : p_end_q[c-1];
		for (int i = first; i < p_end_q[c]; i++) begin
			a = p_addr_q[i];
			prog_we = 1'b1;
			prog_addr = a[IAW-1:0];
			prog_data = p_word_q[i];
			@(negedge clk);
			check_idle();
		end
		prog_we = 1'b0;
	endtask

	task automatic check_beat(input int c);
		logic [15:0] exp_reg;
		logic [15:0] exp_val;
		n_beats++;
		if (exp_idx >= w_end_q[c]) begin
			$display("Extra write-back to r%0d of %h in case %0d", wb_addr, wb_value, c);
			n_extra++;
		end else begin
			exp_reg = w_reg_q[exp_idx];
			exp_val = w_val_q[exp_idx];
			if (wb_addr !== exp_reg[RAW-1:0]) begin
				$display("Fail: wb_addr expected %h got %h in case %0d",
					exp_reg[RAW-1:0], wb_addr, c);
				n_value++;
			end
			if (wb_value !== exp_val) begin
				$display("Fail: wb_value expected %h got %h in case %0d", exp_val, wb_value, c);
				n_value++;
			end
			exp_idx++;
		end
	endtask

	task automatic run_case(input int c);
		bit seen_halt;
		exp_idx = (c == 0) ? 0 : w_end_q[c-1];
		reset_dut();
		load_program(c);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		seen_halt = 1'b0;
		while (!seen_halt) begin
			@(negedge clk);
			if (wb_valid === 1'b1) begin
				check_beat(c);
			end
			if (halted === 1'b1) begin
				seen_halt = 1'b1;
			end
		end
		if (exp_idx < w_end_q[c]) begin
			$display("Case %0d halted with %0d expected write-backs missing",
				c, w_end_q[c] - exp_idx);
			n_missing += w_end_q[c] - exp_idx;
		end
		// Nothing may write back once HALT has passed
		repeat (8) begin
			@(negedge clk);
			if (wb_valid !== 1'b0) begin
				$display("Write-back to r%0d after HALT in case %0d", wb_addr, c);
				n_extra++;
			end
			if (halted !== 1'b1) begin
				$display("Fail: halted expected %h got %h after HALT", 1'b1, halted);
				n_value++;
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		start = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		n_value = 0;
		n_missing = 0;
		n_extra = 0;
		n_other = 0;
		n_beats = 0;
		limit = 0;
		read_cases();
		if (p_end_q.size() == 0 && n_other == 0) begin
			$display("No cases found in the case file");
			n_other++;
		end
		limit = CASE_CYCLES * p_end_q.size();
		for (int c = 0; c < p_end_q.size(); c++) begin
			run_case(c);
		end
		finish_run(1'b0);
	end

	// Limit is set once the case count is known
	initial begin
		cycles = 0;
		while (limit == 0 || cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the DUT did not reach HALT", cycles);
		n_other++;
		finish_run(1'b1);
	end

endmodule

`default_nettype wire

// ==== verif/zhxpu_cases.txt ====
# Lines are P addr word, W reg value or E, all numbers in hex
# P loads a program word, W is the next expected write-back, E ends a case
# ALU functions on LI operands
P 00 195C
P 01 1A3A
P 02 094C
P 03 0951
P 04 0956
P 05 095B
P 06 0A3D
P 07 4000
W 1 005C
W 2 003A
W 3 0096
W 4 0022
W 5 0018
W 6 007E
W 7 FFDE
E
# Immediate extension and dependent chains through bubble and write-through
P 00 19F0
P 01 11FE
P 02 0928
P 03 1280
P 04 0A2D
P 05 0000
P 06 0B30
P 07 4000
W 1 00F0
W 1 00EE
W 2 01DC
W 2 015C
W 3 006E
W 4 015C
E
# Store then load of one address, unrelated LI in between
P 00 192A
P 01 1A09
P 02 2940
P 03 204C
P 04 1D77
P 05 0B30
P 06 4000
W 1 002A
W 2 0009
W 3 002A
W 5 0077
W 4 0054
E
# Untaken and taken branches, words after HALT never run
P 00 1903
P 01 3101
P 02 1A44
P 03 3001
P 04 1BEE
P 05 3801
P 06 1CDD
P 07 11FD
P 08 3101
P 09 1DCC
P 0A 1E66
P 0B 4000
P 0C 1F02
W 1 0003
W 2 0044
W 1 0000
W 6 0066
E

// ==== compile.f ====
+incdir+design
design/zhxpu_pkg.sv
design/stall_ctrl.sv
design/fetch_unit.sv
design/reg_file.sv
design/decoder.sv
design/alu.sv
design/data_mem.sv
design/zhxpu_core.sv
verif/zhxpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator; the log decides pass or fail
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f compile.f --top-module zhxpu_tb -o zhxpu_sim \
	&& ./obj_dir/zhxpu_sim | tee sim.log \
	&& grep -q "SIMULATION PASSED" sim.log \
	&& echo "run.sh: pass" \
	|| { echo "run.sh: fail"; exit 1; }
